//--- src.f
+incdir+include
hw/fir_pkg.sv
hw/sample_credit_fifo.sv
hw/tap_shift_register.sv
hw/symmetric_mac.sv
hw/out_credit_port.sv
hw/fir_decimator_top.sv
verif/tb_clock_gen.sv
verif/tb_fir_decimator.sv

//--- Makefile
# Verilator flow for the FIR decimator testbench.

TOP = tb_fir_decimator

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir

# the run passes only if the testbench printed the pass line.
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- verif/tb_fir_decimator.sv
`default_nettype none

`include "fir_macros.svh"

module tb_fir_decimator
	import fir_pkg::*;
();

	// samples over all tests, sets the run limit.
	localparam int total_samples = 4 + 25 + 200 + 60 + 60 + 100;
	localparam int cycle_limit = total_samples * 20 + 1000;

	logic clk;
	logic resetn;
	logic in_valid;
	sample_t data_in;
	logic out_credit;
	logic in_credit;
	logic out_valid;
	sample_t data_out;

	sample_t hist [`FIR_TAPS];   // model history, index 0 is newest.
	sample_t exp_q [$];          // expected outputs in order.
	sample_t pend_q [$];         // samples waiting to go upstream.
	int accepted = 0;            // samples sent since reset.
	int up_credits = `FIR_IN_DEPTH;
	int down_held = `FIR_OUT_CREDITS; // credits the DUT should hold.
	int owed = 0;                // credits downstream still has to return.
	int ret_mode = 1;            // 0 withheld, 1 steady, 2 random gaps.
	int outs_seen = 0;
	int credits_seen = 0;
	int last_credit_cycle = 0;
	int cycle_cnt = 0;
	int mismatch_errs = 0;
	int other_errs = 0;
	int unsigned lcg_state = 32'd15588;

	tb_clock_gen tb_clock_gen_inst (
		.clk,
		.resetn
	);

	fir_decimator_top fir_decimator_top_inst (
		.clk, .resetn,
		.in_valid, .data_in, .out_credit,
		.in_credit, .out_valid, .data_out
	);

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;  // low bits of an lcg repeat too soon.
	endfunction

	// filter weights as listed for pairs 0 to 9.
	function automatic int pair_coef(input int i);
		case (i)
			0: return `FIR_C0;
			1: return `FIR_C1;
			2: return `FIR_C2;
			3: return `FIR_C3;
			4: return `FIR_C4;
			5: return `FIR_C5;
			6: return `FIR_C6;
			7: return `FIR_C7;
			8: return `FIR_C8;
			default: return `FIR_C9;
		endcase
	endfunction

	// full precision sum of the pair products, then bits 13 to 9.
	function automatic sample_t model_output();
		logic signed [31:0] total;
		total = 0;
		for (int i = 0; i < `FIR_PAIRS; i++)
			total = total + (int'(hist[i]) + int'(hist[`FIR_TAPS-1-i])) * pair_coef(i);
		return total[13:9];
	endfunction

	function automatic void model_accept(input sample_t s);
		for (int i = `FIR_TAPS - 1; i > 0; i--)
			hist[i] = hist[i-1];
		hist[0] = s;
		accepted++;
		if (accepted % `FIR_DECIM == 0)
			exp_q.push_back(model_output()); // one result per group of five.
	endfunction

	// one clock cycle: observe at the falling edge, then drive.
	task automatic run_cycle();
		sample_t exp_val;
		sample_t s;
		logic ret;
		@(negedge clk);
		if (out_valid)
		begin
			outs_seen++;
			if (down_held == 0)
			begin
				other_errs++;
				$display("out_valid at time %0t while the DUT held no credit", $time);
			end
			else
				down_held--;
			owed++;
			if (exp_q.size() == 0)
			begin
				other_errs++;
				$display("output at time %0t when no result was expected", $time);
			end
			else
			begin
				exp_val = exp_q.pop_front();
				if (data_out !== exp_val)
				begin
					mismatch_errs++;
					$display("mismatch at time %0t: output %0d, expected %0d",
						$time, data_out, exp_val);
				end
			end
		end
		if (in_credit)
		begin
			credits_seen++;
			last_credit_cycle = cycle_cnt;
			if (up_credits == `FIR_IN_DEPTH)
			begin
				other_errs++;
				$display("in_credit at time %0t with no sample outstanding", $time);
			end
		end
		// a credit returned now is only spent from the next cycle.
		in_valid = 1'b0;
		if (pend_q.size() != 0 && up_credits != 0)
		begin
			s = pend_q.pop_front();
			in_valid = 1'b1;
			data_in = s;
			up_credits--;
			model_accept(s);
		end
		if (in_credit && up_credits < `FIR_IN_DEPTH)
			up_credits++;
		// downstream hands back consumed credits by mode.
		case (ret_mode)
			0: ret = 1'b0;
			1: ret = 1'b1;
			default: ret = (next_random() % 4) == 0;
		endcase
		out_credit = 1'b0;
		if (owed > 0 && ret)
		begin
			out_credit = 1'b1;
			owed--;
			down_held++;
		end
	endtask

	task automatic queue_random(input int n);
		for (int i = 0; i < n; i++)
			pend_q.push_back(sample_t'(next_random() % 32));
	endtask

	// runs until every sample, result and credit is home.
	task automatic wait_for_drain();
		while (exp_q.size() != 0 || pend_q.size() != 0 || owed != 0
			|| up_credits != `FIR_IN_DEPTH)
			run_cycle();
		repeat (10) run_cycle(); // catches stray outputs.
	endtask

	task automatic check_count(input string what, input int got, input int want);
		if (got != want)
		begin
			mismatch_errs++;
			$display("mismatch at time %0t: %s gave %0d outputs, expected %0d",
				$time, what, got, want);
		end
	endtask

	task automatic reset_state_test();
		int outs_before;
		int creds_before;
		outs_before = outs_seen;
		creds_before = credits_seen;
		repeat (20) run_cycle();
		if (outs_seen != outs_before || credits_seen != creds_before)
		begin
			other_errs++;
			$display("out_valid or in_credit active while idle after reset");
		end
		for (int i = 0; i < `FIR_IN_DEPTH; i++)
			pend_q.push_back('0);
		wait_for_drain(); // back to back on the initial credits.
		if (credits_seen - creds_before != `FIR_IN_DEPTH)
		begin
			other_errs++;
			$display("%0d initial samples returned %0d credits",
				`FIR_IN_DEPTH, credits_seen - creds_before);
		end
	endtask

	task automatic impulse_test();
		int outs_before;
		int acc_before;
		ret_mode = 1;
		outs_before = outs_seen;
		acc_before = accepted;
		pend_q.push_back(5'sd1);
		for (int i = 0; i < 24; i++)
			pend_q.push_back('0);
		wait_for_drain();
		check_count("impulse", outs_seen - outs_before,
			(acc_before + 25) / `FIR_DECIM - acc_before / `FIR_DECIM);
	endtask

	task automatic random_stream_test();
		int outs_before;
		ret_mode = 1;
		outs_before = outs_seen;
		queue_random(200);
		wait_for_drain();
		check_count("random stream", outs_seen - outs_before, 40);
	endtask

	task automatic full_scale_test();
		int outs_before;
		int acc_before;
		ret_mode = 1;
		outs_before = outs_seen;
		acc_before = accepted;
		for (int i = 0; i < 60; i++)
		begin
			if (i < 20 || (i >= 40 && i % 2 == 0))
				pend_q.push_back(-5'sd16);
			else
				pend_q.push_back(5'sd15);
		end
		wait_for_drain();
		check_count("full scale", outs_seen - outs_before,
			(acc_before + 60) / `FIR_DECIM - acc_before / `FIR_DECIM);
	endtask

	task automatic back_pressure_test();
		int outs_before;
		ret_mode = 0;          // downstream keeps its credits.
		outs_before = outs_seen;
		queue_random(60);
		repeat (150) run_cycle();
		check_count("withheld credits", outs_seen - outs_before, `FIR_OUT_CREDITS);
		if (cycle_cnt - last_credit_cycle < 20)
		begin
			other_errs++;
			$display("in_credit kept firing while downstream withheld credits");
		end
		if (pend_q.size() == 0)
		begin
			other_errs++;
			$display("upstream never stalled under back-pressure");
		end
		ret_mode = 1;
		wait_for_drain();
	endtask

	task automatic credit_discipline_test();
		ret_mode = 2;
		queue_random(100);
		wait_for_drain();
		// each sample frees exactly one input slot.
		if (credits_seen != accepted)
		begin
			other_errs++;
			$display("%0d in_credit pulses for %0d samples sent", credits_seen, accepted);
		end
		if (down_held != `FIR_OUT_CREDITS)
		begin
			other_errs++;
			$display("downstream credits did not all return to the DUT");
		end
	endtask

	// hard stop if the DUT stops producing.
	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == cycle_limit)
		begin
			$display("timeout, outputs missing");
			$display("error count: %0d mismatches, %0d other failures",
				mismatch_errs, other_errs);
			$display("Errors found");
			$finish;
		end
	end

	initial
	begin
		in_valid = 1'b0;
		data_in = '0;
		out_credit = 1'b0;
		for (int i = 0; i < `FIR_TAPS; i++)
			hist[i] = '0;  // matches the cleared delay line.
		@(posedge resetn);
		reset_state_test();
		impulse_test();
		random_stream_test();
		full_scale_test();
		back_pressure_test();
		credit_discipline_test();
		$display("error count: %0d mismatches, %0d other failures",
			mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic resetn
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 unit period.
	end

	initial
	begin
		resetn = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;         // released away from the active edge.
	end

endmodule

`default_nettype wire

//--- hw/fir_decimator_top.sv
`default_nettype none

module fir_decimator_top
	import fir_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic in_valid,
	input wire sample_t data_in,
	input wire logic out_credit,
	output logic in_credit,
	output logic out_valid,
	output sample_t data_out
);

	logic pop_valid;      // input buffer to delay line.
	sample_t pop_data;
	logic room;           // output side back to input buffer.
	logic taps_valid;     // full group ready.
	logic res_valid;
	sample_t res_data;

	sample_t tap0, tap1, tap2, tap3, tap4;
	sample_t tap5, tap6, tap7, tap8, tap9;
	sample_t tap10, tap11, tap12, tap13, tap14;
	sample_t tap15, tap16, tap17, tap18, tap19;

	sample_credit_fifo sample_credit_fifo_inst (
		.clk, .resetn,
		.in_valid, .data_in, .room,
		.pop_valid, .pop_data, .in_credit
	);

	tap_shift_register tap_shift_register_inst (
		.clk, .resetn,
		.pop_valid, .pop_data,
		.tap0, .tap1, .tap2, .tap3, .tap4,
		.tap5, .tap6, .tap7, .tap8, .tap9,
		.tap10, .tap11, .tap12, .tap13, .tap14,
		.tap15, .tap16, .tap17, .tap18, .tap19,
		.taps_valid
	);

	symmetric_mac symmetric_mac_inst (
		.clk, .resetn,
		.taps_valid,
		.tap0, .tap1, .tap2, .tap3, .tap4,
		.tap5, .tap6, .tap7, .tap8, .tap9,
		.tap10, .tap11, .tap12, .tap13, .tap14,
		.tap15, .tap16, .tap17, .tap18, .tap19,
		.res_valid, .res_data
	);

	out_credit_port out_credit_port_inst (
		.clk, .resetn,
		.taps_valid, .res_valid, .res_data, .out_credit,
		.room, .out_valid, .data_out
	);

endmodule

`default_nettype wire

//--- hw/out_credit_port.sv
`default_nettype none

`include "fir_macros.svh"

module out_credit_port
	import fir_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic taps_valid,  // a result is on its way, reserve a slot.
	input wire logic res_valid,
	input wire sample_t res_data,
	input wire logic out_credit,  // downstream returns one credit.
	output logic room,            // gates pops at the input buffer.
	output logic out_valid,
	output sample_t data_out
);

	localparam int ptr_w = $clog2(`FIR_OUT_DEPTH);
	localparam int cnt_w = $clog2(`FIR_OUT_DEPTH + 1);
	localparam int cred_w = $clog2(`FIR_OUT_CREDITS + 1);
	localparam logic [cnt_w-1:0] depth_cnt = cnt_w'(`FIR_OUT_DEPTH);
	localparam logic [cred_w-1:0] max_cred = cred_w'(`FIR_OUT_CREDITS);

	sample_t obuf [`FIR_OUT_DEPTH];   // results waiting for a credit.
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] buf_cnt;        // results held.
	logic [cnt_w-1:0] resv_cnt;       // held plus still in the MAC.
	logic [cred_w-1:0] credit_cnt;    // credits from downstream.

	// send whenever a result waits and a credit is held.
	assign out_valid = (buf_cnt != '0) && (credit_cnt != '0);
	assign data_out = obuf[rd_ptr];

	// a new group may only start filling while a slot is free for its result.
	assign room = resv_cnt < depth_cnt;

	always_ff @(posedge clk)
	begin
		if (res_valid)
			obuf[wr_ptr] <= res_data;
	end

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			buf_cnt <= '0;
			resv_cnt <= '0;
			credit_cnt <= max_cred;   // initial grant.
		end
		else
		begin
			if (res_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (out_valid)
				rd_ptr <= rd_ptr + 1'b1;

			if (res_valid && !out_valid)
				buf_cnt <= buf_cnt + 1'b1;
			else if (out_valid && !res_valid)
				buf_cnt <= buf_cnt - 1'b1;

			// slot taken at taps_valid, freed when the result leaves.
			if (taps_valid && !out_valid)
				resv_cnt <= resv_cnt + 1'b1;
			else if (out_valid && !taps_valid)
				resv_cnt <= resv_cnt - 1'b1;

			// a grant and a return together leave the count as is.
			if (out_credit && !out_valid)
				credit_cnt <= credit_cnt + 1'b1;
			else if (out_valid && !out_credit)
				credit_cnt <= credit_cnt - 1'b1;
		end
	end

	// downstream never hands back more than it was given.
	a_credit_bound: assert property (
		@(posedge clk) disable iff (!resetn)
		credit_cnt <= max_cred
	) else $error("out_credit_port: credit count above grant.");

	// the reservation taken at taps_valid guarantees a free slot.
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!resetn)
		res_valid |-> (buf_cnt != depth_cnt)
	) else $error("out_credit_port: result written to full buffer.");

endmodule

`default_nettype wire

//--- hw/symmetric_mac.sv
`default_nettype none

`include "fir_macros.svh"

module symmetric_mac
	import fir_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic taps_valid,  // taps below form a full group.
	input wire sample_t tap0,
	input wire sample_t tap1,
	input wire sample_t tap2,
	input wire sample_t tap3,
	input wire sample_t tap4,
	input wire sample_t tap5,
	input wire sample_t tap6,
	input wire sample_t tap7,
	input wire sample_t tap8,
	input wire sample_t tap9,
	input wire sample_t tap10,
	input wire sample_t tap11,
	input wire sample_t tap12,
	input wire sample_t tap13,
	input wire sample_t tap14,
	input wire sample_t tap15,
	input wire sample_t tap16,
	input wire sample_t tap17,
	input wire sample_t tap18,
	input wire sample_t tap19,
	output logic res_valid,       // two cycles after taps_valid.
	output sample_t res_data
);

	localparam coef_t coef_tab [`FIR_PAIRS] = '{
		`FIR_C0, `FIR_C1, `FIR_C2, `FIR_C3, `FIR_C4,
		`FIR_C5, `FIR_C6, `FIR_C7, `FIR_C8, `FIR_C9
	};

	sample_t tap_vec [`FIR_TAPS];
	logic signed [`FIR_PAIR_W-1:0] pair [`FIR_PAIRS];    // pre-add, one bit of growth.
	logic signed [`FIR_PROD_W-1:0] prod_q [`FIR_PAIRS];  // stage 1 registers.
	logic prod_valid;                                    // stage 1 holds a group.
	acc_t sum_c;
	acc_t total_q;                                       // stage 2 register.

	assign tap_vec[0] = tap0;
	assign tap_vec[1] = tap1;
	assign tap_vec[2] = tap2;
	assign tap_vec[3] = tap3;
	assign tap_vec[4] = tap4;
	assign tap_vec[5] = tap5;
	assign tap_vec[6] = tap6;
	assign tap_vec[7] = tap7;
	assign tap_vec[8] = tap8;
	assign tap_vec[9] = tap9;
	assign tap_vec[10] = tap10;
	assign tap_vec[11] = tap11;
	assign tap_vec[12] = tap12;
	assign tap_vec[13] = tap13;
	assign tap_vec[14] = tap14;
	assign tap_vec[15] = tap15;
	assign tap_vec[16] = tap16;
	assign tap_vec[17] = tap17;
	assign tap_vec[18] = tap18;
	assign tap_vec[19] = tap19;

	for (genvar i = 0; i < `FIR_PAIRS; i++)
	begin : g_pair
		// symmetric taps share a coefficient, so add them first.
		assign pair[i] = `FIR_PAIR_W'(tap_vec[i]) + `FIR_PAIR_W'(tap_vec[`FIR_TAPS-1-i]);

		always_ff @(posedge clk)
		begin
			if (taps_valid)
				prod_q[i] <= `FIR_PROD_W'(pair[i] * coef_tab[i]); // fits, |p| <= 32*193.
		end
	end

	always_comb
	begin
		sum_c = '0;
		for (int i = 0; i < `FIR_PAIRS; i++)
			sum_c = sum_c + acc_t'(prod_q[i]);   // sign extended to 17 bits.
	end

	always_ff @(posedge clk)
	begin
		if (prod_valid)
			total_q <= sum_c;
	end

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			prod_valid <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			prod_valid <= taps_valid;
			res_valid <= prod_valid;
		end
	end

	// plain bit slice, no rounding and no saturation.
	assign res_data = total_q[`FIR_OUT_LSB +: `FIR_DATA_W];

endmodule

`default_nettype wire

//--- hw/tap_shift_register.sv
`default_nettype none

`include "fir_macros.svh"

module tap_shift_register
	import fir_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic pop_valid,   // shift enable.
	input wire sample_t pop_data,
	output sample_t tap0,         // newest sample.
	output sample_t tap1,
	output sample_t tap2,
	output sample_t tap3,
	output sample_t tap4,
	output sample_t tap5,
	output sample_t tap6,
	output sample_t tap7,
	output sample_t tap8,
	output sample_t tap9,
	output sample_t tap10,
	output sample_t tap11,
	output sample_t tap12,
	output sample_t tap13,
	output sample_t tap14,
	output sample_t tap15,
	output sample_t tap16,
	output sample_t tap17,
	output sample_t tap18,
	output sample_t tap19,        // oldest sample.
	output logic taps_valid       // taps hold a full decimation group.
);

	sample_t dly [`FIR_TAPS];     // delay line, index 0 is newest.
	phase_t state;
	phase_t next_state;
	logic last_shift;             // this pop completes a group of five.

	always_comb
	begin
		next_state = state;
		last_shift = 1'b0;
		if (pop_valid)
		begin
			unique case (state)
				PH_INIT, PH0: next_state = PH1;
				PH1: next_state = PH2;
				PH2: next_state = PH3;
				PH3: next_state = PH4;
				PH4:
				begin
					next_state = PH0;   // group done, start the next one.
					last_shift = 1'b1;
				end
				default: next_state = PH_INIT;
			endcase
		end
	end

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			state <= PH_INIT;
			taps_valid <= 1'b0;
			for (int i = 0; i < `FIR_TAPS; i++)
				dly[i] <= '0;   // history starts at zero.
		end
		else
		begin
			state <= next_state;
			taps_valid <= last_shift; // high the cycle after the fifth shift.
			if (pop_valid)
			begin
				dly[0] <= pop_data;
				for (int i = 1; i < `FIR_TAPS; i++)
					dly[i] <= dly[i-1];
			end
		end
	end

	assign tap0 = dly[0];
	assign tap1 = dly[1];
	assign tap2 = dly[2];
	assign tap3 = dly[3];
	assign tap4 = dly[4];
	assign tap5 = dly[5];
	assign tap6 = dly[6];
	assign tap7 = dly[7];
	assign tap8 = dly[8];
	assign tap9 = dly[9];
	assign tap10 = dly[10];
	assign tap11 = dly[11];
	assign tap12 = dly[12];
	assign tap13 = dly[13];
	assign tap14 = dly[14];
	assign tap15 = dly[15];
	assign tap16 = dly[16];
	assign tap17 = dly[17];
	assign tap18 = dly[18];
	assign tap19 = dly[19];

	a_phase_legal: assert property (
		@(posedge clk) disable iff (!resetn)
		state inside {PH_INIT, PH0, PH1, PH2, PH3, PH4}
	) else $error("tap_shift_register: phase outside enum.");

endmodule

`default_nettype wire

//--- hw/sample_credit_fifo.sv
`default_nettype none

`include "fir_macros.svh"

module sample_credit_fifo
	import fir_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic in_valid,      // upstream spends one credit.
	input wire sample_t data_in,
	input wire logic room,          // output side can take another group.
	output logic pop_valid,
	output sample_t pop_data,
	output logic in_credit          // one credit back per pop.
);

	localparam int ptr_w = $clog2(`FIR_IN_DEPTH);
	localparam int cnt_w = $clog2(`FIR_IN_DEPTH + 1);
	localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`FIR_IN_DEPTH);

	sample_t mem [`FIR_IN_DEPTH];   // circular storage.
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;        // entries held.

	// pop as soon as anything is held and the output has room.
	assign pop_valid = (count != '0) && room;
	assign pop_data = mem[rd_ptr];
	assign in_credit = pop_valid;   // the freed slot goes straight back upstream.

	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
			if (pop_valid)
				rd_ptr <= rd_ptr + 1'b1;
			if (in_valid && !pop_valid)
				count <= count + 1'b1;
			else if (pop_valid && !in_valid)
				count <= count - 1'b1;
		end
	end

	// upstream only writes with a credit in hand, so a full buffer
	// never sees a write. a hit here means the credit loop is broken.
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (!resetn)
		in_valid |-> (count != full_cnt)
	) else $error("sample_credit_fifo: write while full.");

endmodule

`default_nettype wire

//--- hw/fir_pkg.sv
`default_nettype none

`include "fir_macros.svh"

package fir_pkg;

	typedef logic signed [`FIR_DATA_W-1:0] sample_t; // one filter sample.
	typedef logic signed [`FIR_COEF_W-1:0] coef_t;   // one tap pair weight.
	typedef logic signed [`FIR_ACC_W-1:0] acc_t;     // full precision total.

	// phase counts the samples of the current group already shifted in.
	// PH_INIT is only seen between reset and the first shift.
	typedef enum logic [2:0] {
		PH_INIT,
		PH0,
		PH1,
		PH2,
		PH3,
		PH4
	} phase_t;

endpackage

`default_nettype wire

//--- include/fir_macros.svh
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// datapath widths.
`define FIR_DATA_W 5    // input and output sample.
`define FIR_COEF_W 9    // signed coefficient.
`define FIR_PAIR_W 6    // sum of a symmetric tap pair.
`define FIR_PROD_W 14   // pair times coefficient.
`define FIR_ACC_W 17    // sum of the ten products.
`define FIR_OUT_LSB 9   // output keeps total[13:9].

// filter shape.
`define FIR_TAPS 20
`define FIR_PAIRS 10
`define FIR_DECIM 5     // one output per five accepted samples.

// buffering and credits.
`define FIR_IN_DEPTH 4      // also the upstream credits after reset.
`define FIR_OUT_DEPTH 4
`define FIR_OUT_CREDITS 2   // credits granted by downstream at reset.

// pair i multiplies tap i plus tap 19-i.
`define FIR_C0 (9'sd1)
`define FIR_C1 (-9'sd9)
`define FIR_C2 (-9'sd2)
`define FIR_C3 (9'sd13)
`define FIR_C4 (9'sd14)
`define FIR_C5 (-9'sd14)
`define FIR_C6 (-9'sd39)
`define FIR_C7 (-9'sd3)
`define FIR_C8 (9'sd99)
`define FIR_C9 (9'sd193)   // center pair, largest weight.

`endif
